// File: source/fpDivPkg.sv
//------------------------------
// half precision divider types
//------------------------------

package fpDivPkg;

    //------------------------------
    // binary16 field widths
    //------------------------------

    // one packed binary16 value with sign, exponent and fraction
    typedef logic [15:0] halfT;

    // biased exponent field as stored in the word
    typedef logic [4:0] expT;

    // stored fraction without the hidden bit
    typedef logic [9:0] fracT;

    // significand with the implicit leading one in bit 10
    typedef logic [10:0] sigT;

    // raw quotient from the mantissa divider
    // bit 11 is the integer bit when dividend sig >= divisor sig
    typedef logic [11:0] quotT;

    // signed working exponent
    // covers effective exponents well below zero and past the max field
    typedef logic signed [6:0] wideExpT;

    //------------------------------
    // format constants
    //------------------------------

    // exponent bias of binary16
    localparam int expBias = 15;

    // all ones exponent, used for infinity
    localparam int expMaxField = 31;

    // one quotient bit per iteration, 12 bits in total
    localparam int quotSteps = 12;

endpackage

// File: source/fpOperandStage.sv
//------------------------------
// operand unpack stage
//------------------------------

`timescale 1ns/1ps

module fpOperandStage import fpDivPkg::*; (
    input  logic    clk,
    input  logic    arstN,
    input  logic    loadEn,
    input  halfT    opA,
    input  halfT    opB,
    output sigT     dividendSig,
    output sigT     divisorSig,
    output logic    resSign,
    output wideExpT expDiff,
    output logic    aZero,
    output logic    bZero
);

    // unpacked fields of both operands
    expT     expA;
    expT     expB;
    fracT    fracA;
    fracT    fracB;

    // leading zero count of a subnormal dividend, 11 when all zero
    logic [3:0] lzCount;

    // normalized dividend and its effective exponent
    sigT     dividendNext;
    wideExpT effExpA;

    assign expA  = opA[14:10];
    assign fracA = opA[9:0];
    assign expB  = opB[14:10];
    assign fracB = opB[9:0];

    //------------------------------
    // subnormal dividend handling
    //------------------------------

    // scan upward so the highest set bit wins
    always_comb begin
        lzCount = 4'd11;
        for (int i = 0; i < 10; i++) begin
            if (fracA[i]) begin
                lzCount = 4'(10 - i);
            end
        end
    end

    always_comb begin
        if (expA != '0) begin
            // normal dividend keeps its field exponent
            dividendNext = {1'b1, fracA};
            effExpA      = wideExpT'({2'b00, expA});
        end else begin
            // shift until bit 10 is set, exponent drops by the same amount
            dividendNext = sigT'({1'b0, fracA} << lzCount);
            effExpA      = 7'sd1 - wideExpT'({3'b000, lzCount});
        end
    end

    // the divider takes the normalized dividend on the load edge itself
    assign dividendSig = dividendNext;

    //------------------------------
    // operand registers
    //------------------------------

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            divisorSig  <= '0;
            resSign     <= 1'b0;
            expDiff     <= '0;
            aZero       <= 1'b0;
            bZero       <= 1'b0;
        end else if (loadEn) begin
            // divisor is assumed normal, hidden one always present
            divisorSig  <= {1'b1, fracB};
            resSign     <= opA[15] ^ opB[15];
            // unbiased difference, bias is added back in the pack stage
            expDiff     <= effExpA - wideExpT'({2'b00, expB});
            // magnitude tests ignore the sign bit so -0 counts as zero
            aZero       <= (opA[14:0] == '0);
            bZero       <= (opB[14:0] == '0);
        end
    end

endmodule

// File: source/mantDivider.sv
//------------------------------
// restoring mantissa divider
//------------------------------

`timescale 1ns/1ps

module mantDivider import fpDivPkg::*; (
    input  logic clk,
    input  logic arstN,
    input  logic loadEn,
    input  logic stepEn,
    input  sigT  dividendSig,
    input  sigT  divisorSig,
    output quotT quotBits,
    output logic remNonZero
);

    // partial remainder
    // stays below twice the divisor, so 12 bits are enough
    logic [11:0] rem;

    // trial subtraction for the current step
    logic [11:0] remSub;
    logic [11:0] remNext;
    logic        remGeq;

    quotT quot;

    //------------------------------
    // one step of the recurrence
    //------------------------------

    assign remGeq = (rem >= {1'b0, divisorSig});
    assign remSub = rem - {1'b0, divisorSig};

    // restore by keeping the old remainder when the trial fails
    assign remNext = remGeq ? remSub : rem;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rem  <= '0;
            quot <= '0;
        end else if (loadEn) begin
            // first step compares the dividend at full weight
            rem  <= {1'b0, dividendSig};
            quot <= '0;
        end else if (stepEn) begin
            // remNext is below the divisor, doubling fits in 12 bits
            rem  <= {remNext[10:0], 1'b0};
            quot <= {quot[10:0], remGeq};
        end
    end

    //------------------------------
    // outputs
    //------------------------------

    // after 12 steps quot is floor(dividend * 2048 / divisor)
    assign quotBits = quot;

    // doubling does not change zero vs nonzero, so the sticky test is direct
    assign remNonZero = (rem != '0);

endmodule

// File: source/normPack.sv
//------------------------------
// normalize and pack
//------------------------------

`timescale 1ns/1ps

module normPack import fpDivPkg::*; (
    input  logic    clk,
    input  logic    arstN,
    input  logic    packEn,
    input  logic    resSign,
    input  wideExpT expDiff,
    input  logic    aZero,
    input  logic    bZero,
    input  quotT    quotBits,
    input  logic    remNonZero,
    output halfT    quotient,
    output logic    divByZero,
    output logic    overflow,
    output logic    underflow,
    output logic    inexact
);

    // normalized fields before range checks
    fracT    fracRes;
    wideExpT expRes;
    logic    droppedBit;
    logic    inexactRaw;

    // next register values
    halfT    quotNext;
    logic    dbzNext;
    logic    ovfNext;
    logic    unfNext;
    logic    inxNext;

    //------------------------------
    // quotient normalization
    //------------------------------

    always_comb begin
        if (quotBits[11]) begin
            // quotient in [2, 4) relative to the sig scale, shift right by one
            fracRes    = quotBits[10:1];
            expRes     = expDiff + wideExpT'(expBias);
            droppedBit = quotBits[0];
        end else begin
            // leading one already in bit 10
            fracRes    = quotBits[9:0];
            expRes     = expDiff + wideExpT'(expBias - 1);
            droppedBit = 1'b0;
        end
    end

    // truncation toward zero, anything discarded makes it inexact
    assign inexactRaw = droppedBit | remNonZero;

    //------------------------------
    // special cases in priority order
    //------------------------------

    always_comb begin
        quotNext = '0;
        dbzNext  = 1'b0;
        ovfNext  = 1'b0;
        unfNext  = 1'b0;
        inxNext  = 1'b0;
        if (bZero) begin
            quotNext = {resSign, expT'(expMaxField), fracT'(0)};
            dbzNext  = 1'b1;
        end else if (aZero) begin
            quotNext = {resSign, 15'b0};
        end else if (expRes >= wideExpT'(expMaxField)) begin
            // too large for the format, saturate to infinity
            quotNext = {resSign, expT'(expMaxField), fracT'(0)};
            ovfNext  = 1'b1;
            inxNext  = 1'b1;
        end else if (expRes <= 7'sd0) begin
            // subnormal results are flushed
            quotNext = {resSign, 15'b0};
            unfNext  = 1'b1;
            inxNext  = 1'b1;
        end else begin
            quotNext = {resSign, expT'(expRes), fracRes};
            inxNext  = inexactRaw;
        end
    end

    //------------------------------
    // result registers
    //------------------------------

    // values hold until the next pack
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            quotient  <= '0;
            divByZero <= 1'b0;
            overflow  <= 1'b0;
            underflow <= 1'b0;
            inexact   <= 1'b0;
        end else if (packEn) begin
            quotient  <= quotNext;
            divByZero <= dbzNext;
            overflow  <= ovfNext;
            underflow <= unfNext;
            inexact   <= inxNext;
        end
    end

endmodule

// File: source/divControl.sv
//------------------------------
// divider sequencing FSM
//------------------------------

`timescale 1ns/1ps

module divControl import fpDivPkg::*; (
    input  logic clk,
    input  logic arstN,
    input  logic start,
    output logic loadEn,
    output logic stepEn,
    output logic packEn,
    output logic busy,
    output logic done
);

    // finish is the single done cycle
    typedef enum logic [1:0] {
        idle,
        divide,
        pack,
        finish
    } stateT;

    stateT state;
    stateT stateNext;

    // counts divide cycles 0 .. quotSteps-1
    logic [$clog2(quotSteps)-1:0] stepCnt;
    logic                         lastStep;

    assign lastStep = (int'(stepCnt) == quotSteps - 1);

    //------------------------------
    // next state
    //------------------------------

    always_comb begin
        stateNext = state;
        case (state)
            // start while busy never reaches this branch
            idle:    if (start) stateNext = divide;
            divide:  if (lastStep) stateNext = pack;
            pack:    stateNext = finish;
            finish:  stateNext = idle;
            default: stateNext = idle;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state   <= idle;
            stepCnt <= '0;
        end else begin
            state <= stateNext;
            if (state == divide) begin
                stepCnt <= stepCnt + 1'b1;
            end else begin
                stepCnt <= '0;
            end
        end
    end

    //------------------------------
    // datapath strobes
    //------------------------------

    // operands are captured on the same edge that accepts start
    assign loadEn = (state == idle) && start;
    assign stepEn = (state == divide);
    assign packEn = (state == pack);
    assign busy   = (state != idle);
    assign done   = (state == finish);

endmodule

// File: source/fpDivUnit.sv
//------------------------------
// binary16 divider top
//------------------------------

`timescale 1ns/1ps

module fpDivUnit import fpDivPkg::*; (
    input  logic clk,
    input  logic arstN,
    input  logic start,
    input  halfT opA,
    input  halfT opB,
    output halfT quotient,
    output logic divByZero,
    output logic overflow,
    output logic underflow,
    output logic inexact,
    output logic busy,
    output logic done
);

    // control strobes
    logic    loadEn;
    logic    stepEn;
    logic    packEn;

    // operand stage to divider and pack
    sigT     dividendSig;
    sigT     divisorSig;
    logic    resSign;
    wideExpT expDiff;
    logic    aZero;
    logic    bZero;

    // divider to pack
    quotT    quotBits;
    logic    remNonZero;

    divControl divControl_i (
        .clk    (clk),
        .arstN  (arstN),
        .start  (start),
        .loadEn (loadEn),
        .stepEn (stepEn),
        .packEn (packEn),
        .busy   (busy),
        .done   (done)
    );

    fpOperandStage fpOperandStage_i (
        .clk         (clk),
        .arstN       (arstN),
        .loadEn      (loadEn),
        .opA         (opA),
        .opB         (opB),
        .dividendSig (dividendSig),
        .divisorSig  (divisorSig),
        .resSign     (resSign),
        .expDiff     (expDiff),
        .aZero       (aZero),
        .bZero       (bZero)
    );

    mantDivider mantDivider_i (
        .clk         (clk),
        .arstN       (arstN),
        .loadEn      (loadEn),
        .stepEn      (stepEn),
        .dividendSig (dividendSig),
        .divisorSig  (divisorSig),
        .quotBits    (quotBits),
        .remNonZero  (remNonZero)
    );

    normPack normPack_i (
        .clk        (clk),
        .arstN      (arstN),
        .packEn     (packEn),
        .resSign    (resSign),
        .expDiff    (expDiff),
        .aZero      (aZero),
        .bZero      (bZero),
        .quotBits   (quotBits),
        .remNonZero (remNonZero),
        .quotient   (quotient),
        .divByZero  (divByZero),
        .overflow   (overflow),
        .underflow  (underflow),
        .inexact    (inexact)
    );

endmodule

// File: bench/fpDivChecker.sv
//------------------------------
// divider result checker
//------------------------------

`timescale 1ns/1ps

module fpDivChecker import fpDivPkg::*; (
    input  logic clk,
    input  logic arstN,
    input  logic start,
    input  halfT opA,
    input  halfT opB,
    input  halfT quotient,
    input  logic divByZero,
    input  logic overflow,
    input  logic underflow,
    input  logic inexact,
    input  logic busy,
    input  logic done,
    output int   errorCount,
    output int   resultCount
);

    // start is seen half a cycle before its accepting edge
    // done is seen half a cycle after edge quotSteps+1
    localparam int doneEdge = quotSteps + 2;

    // expected results in issue order, flags packed as {dbz, ovf, unf, inx}
    halfT       expQuot[$];
    logic [3:0] expFlags[$];
    string      expName[$];

    logic       pending = 1'b0;
    int         edgesSince = 0;
    int         testIdx = 0;
    halfT       lastQuot = '0;
    logic [3:0] lastFlags = '0;
    string      lastName = "reset";

    //------------------------------
    // reference model
    //------------------------------

    function automatic void modelDivide(input halfT a, input halfT b,
                                        output halfT q, output logic [3:0] flags);
        logic sign;
        int   sigA;
        int   sigB;
        int   expA;
        int   expB;
        int   quot;
        int   rem;
        int   e;
        fracT frac;
        logic dropped;
        sign  = a[15] ^ b[15];
        flags = 4'b0000;
        q     = {sign, 15'b0};
        if (b[14:0] == 15'b0) begin
            q     = {sign, expT'(expMaxField), 10'b0};
            flags = 4'b1000;
        end else if (a[14:0] != 15'b0) begin
            expA = int'(a[14:10]);
            sigA = int'(a[9:0]);
            if (expA == 0) begin
                // subnormal, bring the leading one up to the hidden position
                expA = 1;
                while (sigA < 1024) begin
                    sigA = sigA * 2;
                    expA = expA - 1;
                end
            end else begin
                sigA = sigA + 1024;
            end
            sigB = 1024 + int'(b[9:0]);
            expB = int'(b[14:10]);
            quot = (sigA << (quotSteps - 1)) / sigB;
            rem  = (sigA << (quotSteps - 1)) % sigB;
            // quotient of two sigs lies in (0.5, 2)
            if (quot >= 2048) begin
                frac    = fracT'(quot >> 1);
                e       = expA - expB + expBias;
                dropped = (quot % 2) != 0;
            end else begin
                frac    = fracT'(quot);
                e       = expA - expB + expBias - 1;
                dropped = 1'b0;
            end
            if (e >= expMaxField) begin
                q     = {sign, expT'(expMaxField), 10'b0};
                flags = 4'b0101;
            end else if (e <= 0) begin
                flags = 4'b0011;
            end else begin
                q     = {sign, expT'(e), frac};
                flags = {3'b000, dropped || (rem != 0)};
            end
        end
    endfunction

    //------------------------------
    // compare helpers
    //------------------------------

    task automatic compareHalf(input string testName, input halfT expVal, input halfT actVal);
        if (actVal !== expVal) begin
            errorCount++;
            $display("Mismatch %s quotient: expected %h, actual %h", testName, expVal, actVal);
        end
    endtask

    task automatic compareFlags(input string testName, input logic [3:0] expF,
                                input logic [3:0] actF);
        string names[4];
        names = '{"divByZero", "overflow", "underflow", "inexact"};
        for (int i = 0; i < 4; i++) begin
            if (actF[3 - i] !== expF[3 - i]) begin
                errorCount++;
                $display("Mismatch %s %s: expected %b, actual %b",
                         testName, names[i], expF[3 - i], actF[3 - i]);
            end
        end
    endtask

    //------------------------------
    // port monitor
    //------------------------------

    // falling edge, half a cycle after the DUT registers settle
    always @(negedge clk) begin
        logic       wasPending;
        logic [3:0] actFlags;
        halfT       q;
        logic [3:0] f;
        actFlags = {divByZero, overflow, underflow, inexact};
        if (!arstN) begin
            expQuot.delete();
            expFlags.delete();
            expName.delete();
            pending     = 1'b0;
            edgesSince  = 0;
            lastQuot    = '0;
            lastFlags   = '0;
            lastName    = "reset";
            errorCount  = 0;
            resultCount = 0;
        end else begin
            wasPending = pending;
            if (pending) begin
                edgesSince++;
            end
            // busy spans the whole division including the done cycle
            if (busy !== pending) begin
                errorCount++;
                $display("busy was %b but should be %b (last division %s)",
                         busy, pending, lastName);
            end
            if (done) begin
                if (!pending) begin
                    errorCount++;
                    $display("done pulsed with no division in flight (after %s)", lastName);
                end else begin
                    if (edgesSince != doneEdge) begin
                        errorCount++;
                        $display("done for %s rose %0d edges after start instead of %0d",
                                 expName[0], edgesSince - 1, doneEdge - 1);
                    end
                    compareHalf(expName[0], expQuot[0], quotient);
                    compareFlags(expName[0], expFlags[0], actFlags);
                    lastName = expName.pop_front();
                    void'(expQuot.pop_front());
                    void'(expFlags.pop_front());
                    pending = 1'b0;
                    resultCount++;
                end
                lastQuot  = quotient;
                lastFlags = actFlags;
            end else begin
                // outputs must hold between packs
                compareHalf({"hold after ", lastName}, lastQuot, quotient);
                compareFlags({"hold after ", lastName}, lastFlags, actFlags);
                if (pending && edgesSince >= doneEdge) begin
                    errorCount++;
                    $display("done never came for %s", expName[0]);
                    lastName = expName.pop_front();
                    void'(expQuot.pop_front());
                    void'(expFlags.pop_front());
                    pending = 1'b0;
                end
            end
            // a start seen while a division runs is ignored
            if (start && !wasPending) begin
                modelDivide(opA, opB, q, f);
                expQuot.push_back(q);
                expFlags.push_back(f);
                expName.push_back($sformatf("div%0d a=%h b=%h", testIdx, opA, opB));
                testIdx++;
                pending    = 1'b1;
                edgesSince = 0;
            end
        end
    end

endmodule

// File: bench/fpDivBench.sv
//------------------------------
// divider testbench top
//------------------------------

`timescale 1ns/1ps

module fpDivBench import fpDivPkg::*; ();

    localparam int numTests    = 400;
    localparam int clkPeriodNs = 4;
    localparam int resetCycles = 8;
    // about 20 cycles per division with its idle gap, plus some slack
    localparam int watchdogNs  = (numTests * 20 + 200) * clkPeriodNs;

    logic clk = 1'b0;
    logic arstN;
    logic start;
    halfT opA;
    halfT opB;
    halfT quotient;
    logic divByZero;
    logic overflow;
    logic underflow;
    logic inexact;
    logic busy;
    logic done;
    int   errorCount;
    int   resultCount;

    always #(clkPeriodNs / 2) clk = ~clk;

    fpDivUnit fpDivUnit_i (
        .clk(clk), .arstN(arstN), .start(start), .opA(opA), .opB(opB),
        .quotient(quotient), .divByZero(divByZero), .overflow(overflow),
        .underflow(underflow), .inexact(inexact), .busy(busy), .done(done)
    );

    fpDivChecker fpDivChecker_i (
        .clk(clk), .arstN(arstN), .start(start), .opA(opA), .opB(opB),
        .quotient(quotient), .divByZero(divByZero), .overflow(overflow),
        .underflow(underflow), .inexact(inexact), .busy(busy), .done(done),
        .errorCount(errorCount), .resultCount(resultCount)
    );

    //------------------------------
    // operand generators
    //------------------------------

    function automatic halfT randNormal(input int expLo, input int expHi);
        return {1'($urandom_range(1, 0)), expT'($urandom_range(expHi, expLo)),
                fracT'($urandom())};
    endfunction

    // random leading bit so every normalize shift shows up
    function automatic halfT randSubnormal();
        int lead;
        lead = $urandom_range(9, 0);
        return {1'($urandom_range(1, 0)), 5'b0,
                fracT'((1 << lead) | ($urandom() & ((1 << lead) - 1)))};
    endfunction

    // exact binary16 form of an integer 1 .. 2047
    function automatic halfT intToHalf(input int n);
        int msb;
        msb = 0;
        for (int i = 0; i <= 10; i++) begin
            if (((n >> i) & 1) != 0) begin
                msb = i;
            end
        end
        return {1'($urandom_range(1, 0)), expT'(expBias + msb), fracT'(n << (10 - msb))};
    endfunction

    task automatic pickOperands(output halfT a, output halfT b);
        int kind;
        kind = $urandom_range(9, 0);
        case (kind)
            4:       begin a = randSubnormal(); b = randNormal(1, 30); end
            5:       begin a = {1'($urandom_range(1, 0)), 15'b0}; b = randNormal(1, 30); end
            6:       begin a = randNormal(1, 30); b = {1'($urandom_range(1, 0)), 15'b0}; end
            7:       begin a = randNormal(1, 30); b = intToHalf($urandom_range(2047, 1)); end
            // large over small pushes past the top exponent
            8:       begin a = randNormal(24, 30); b = randNormal(1, 8); end
            // small over large lands below the normal range
            9:       begin a = randNormal(1, 8); b = randNormal(22, 30); end
            default: begin a = randNormal(1, 30); b = randNormal(1, 30); end
        endcase
    endtask

    //------------------------------
    // one division
    //------------------------------

    // entered and left 1 ns after a rising edge
    task automatic runDivision(input halfT a, input halfT b, input logic extraStart);
        int extraDelay;
        while (busy) begin
            @(posedge clk);
            #1;
        end
        opA   = a;
        opB   = b;
        start = 1'b1;
        @(posedge clk);
        #1;
        // operands were taken at that edge, scramble them
        start = 1'b0;
        opA   = halfT'($urandom());
        opB   = halfT'($urandom());
        if (extraStart) begin
            extraDelay = $urandom_range(10, 0);
            repeat (extraDelay) begin
                @(posedge clk);
                #1;
            end
            start = 1'b1;
            @(posedge clk);
            #1;
            start = 1'b0;
        end
        while (!done) begin
            @(posedge clk);
            #1;
        end
    endtask

    initial begin
        halfT a;
        halfT b;
        int   gap;
        void'($urandom(52830));
        arstN = 1'b0;
        start = 1'b0;
        opA   = '0;
        opB   = '0;
        repeat (resetCycles) @(posedge clk);
        #1;
        arstN = 1'b1;
        // a few idle cycles with reset values visible
        repeat (3) begin
            @(posedge clk);
            #1;
        end
        for (int t = 0; t < numTests; t++) begin
            pickOperands(a, b);
            runDivision(a, b, $urandom_range(3, 0) == 0);
            gap = $urandom_range(4, 0);
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
        end
        repeat (4) @(posedge clk);
        $display("errors: %0d, results checked: %0d of %0d", errorCount, resultCount, numTests);
        if (errorCount == 0 && resultCount == numTests) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(watchdogNs);
        $display("timeout: run did not finish all divisions within %0d ns", watchdogNs);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: fpDivUnit.f
source/fpDivPkg.sv
source/fpOperandStage.sv
source/mantDivider.sv
source/normPack.sv
source/divControl.sv
source/fpDivUnit.sv
bench/fpDivChecker.sv
bench/fpDivBench.sv

// File: run.sh
#!/bin/sh
# build and run the divider testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary -f fpDivUnit.f --top-module fpDivBench -o fpDivSim

simOut="$(./obj_dir/fpDivSim)"
echo "$simOut"

if echo "$simOut" | grep -qF '*** PASSED ***'; then
    exit 0
fi
exit 1
